// ==== rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// register address width, 32 registers
`define RV_REG_AW 5

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

// major opcodes, inst[6:0]
// addi lives here with funct3 zero
`define RV_OP_IMM 7'b001_0011

// load upper immediate
`define RV_OP_LUI 7'b011_0111

// add upper immediate to pc
`define RV_OP_AUIPC 7'b001_0111

// jump and link, pc relative
`define RV_OP_JAL 7'b110_1111

// jump and link, register relative
`define RV_OP_JALR 7'b110_0111

// ebreak and friends
`define RV_OP_SYSTEM 7'b111_0011

`endif

// ==== rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

  // i-type layout, addi / jalr / ebreak
  typedef struct packed {
    logic [11:0]            imm_11_0;
    logic [`RV_REG_AW-1:0]  rs1;
    logic [2:0]             funct3;
    logic [`RV_REG_AW-1:0]  rd;
    logic [6:0]             opcode;
  } inst_i_t;

  // u-type layout, lui / auipc
  typedef struct packed {
    logic [19:0]            imm_31_12;
    logic [`RV_REG_AW-1:0]  rd;
    logic [6:0]             opcode;
  } inst_u_t;

  // j-type layout, scrambled offset bits
  typedef struct packed {
    logic                   imm_20;
    logic [9:0]             imm_10_1;
    logic                   imm_11;
    logic [7:0]             imm_19_12;
    logic [`RV_REG_AW-1:0]  rd;
    logic [6:0]             opcode;
  } inst_j_t;

  // one instruction word, seen through each format
  typedef union packed {
    inst_i_t                i;
    inst_u_t                u;
    inst_j_t                j;
    logic [`RV_XLEN-1:0]    raw;
  } inst_word_u;

  // immediate format in use
  typedef enum logic [1:0] {imm_i, imm_u, imm_j} imm_sel_e;

  // first adder operand
  typedef enum logic [1:0] {op_a_rs1, op_a_pc, op_a_zero} op_a_sel_e;

  // next pc source
  typedef enum logic {pc_seq, pc_jump} pc_sel_e;

  // write-back source
  typedef enum logic {wb_sum, wb_link} wb_sel_e;

endpackage

// ==== rv_ctrl.sv ====
`include "rv_consts.svh"

module rv_ctrl import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`RV_XLEN-1:0]   inst,
  input  logic                  inst_valid,
  output logic                  inst_ready,
  output logic                  halted,
  output logic                  fire,
  output logic                  reg_we,
  output logic [`RV_REG_AW-1:0] rs1,
  output logic [`RV_REG_AW-1:0] rd,
  output imm_sel_e              imm_sel,
  output op_a_sel_e             op_a_sel,
  output pc_sel_e               pc_sel,
  output wb_sel_e               wb_sel
);

  inst_word_u iw;
  logic       is_ebreak;
  // opcode is one of the five writers
  logic       writes_rd;

  assign iw = inst;

  // register fields sit at the same place in every format
  assign rs1 = iw.i.rs1;
  assign rd  = iw.i.rd;

  // ebreak is the exact word 0x00100073
  assign is_ebreak = (iw.i.opcode == `RV_OP_SYSTEM) &&
                     (iw.i.funct3 == 3'b000) &&
                     (iw.i.imm_11_0 == 12'h001) &&
                     (iw.i.rs1 == '0) &&
                     (iw.i.rd == '0);

  // two states: run (halted low) and halt
  // halt is sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted <= 1'b0;
    end else if (fire && is_ebreak) begin
      halted <= 1'b1;
    end
  end

  // only a halt ever withholds ready
  assign inst_ready = !halted;
  assign fire       = inst_valid && inst_ready;

  // opcode table, default is a no-op that falls through to pc+4
  always_comb begin
    imm_sel   = imm_i;
    op_a_sel  = op_a_zero;
    pc_sel    = pc_seq;
    wb_sel    = wb_sum;
    writes_rd = 1'b0;
    case (iw.i.opcode)
      `RV_OP_IMM: begin
        // addi only, other funct3 values retire as no-ops
        if (iw.i.funct3 == 3'b000) begin
          op_a_sel  = op_a_rs1;
          writes_rd = 1'b1;
        end
      end
      `RV_OP_LUI: begin
        imm_sel   = imm_u;
        writes_rd = 1'b1;
      end
      `RV_OP_AUIPC: begin
        imm_sel   = imm_u;
        op_a_sel  = op_a_pc;
        writes_rd = 1'b1;
      end
      `RV_OP_JAL: begin
        imm_sel   = imm_j;
        op_a_sel  = op_a_pc;
        pc_sel    = pc_jump;
        wb_sel    = wb_link;
        writes_rd = 1'b1;
      end
      `RV_OP_JALR: begin
        if (iw.i.funct3 == 3'b000) begin
          op_a_sel  = op_a_rs1;
          pc_sel    = pc_jump;
          wb_sel    = wb_link;
          writes_rd = 1'b1;
        end
      end
      default: begin
        // system and everything else, no write
        writes_rd = 1'b0;
      end
    endcase
  end

  // x0 writes are dropped here, not in the regfile
  assign reg_we = fire && writes_rd && (rd != '0);

endmodule

// ==== rv_imm_gen.sv ====
`include "rv_consts.svh"

module rv_imm_gen import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] inst,
  input  imm_sel_e            imm_sel,
  output logic [`RV_XLEN-1:0] imm
);

  inst_word_u iw;
  // sign bit is inst[31] in all three formats
  logic       sign;

  assign iw   = inst;
  assign sign = iw.raw[`RV_XLEN-1];

  always_comb begin
    case (imm_sel)
      imm_i: begin
        // 12-bit signed
        imm = {{20{sign}}, iw.i.imm_11_0};
      end
      imm_u: begin
        // upper 20 bits, already shifted by 12
        imm = {iw.u.imm_31_12, 12'h000};
      end
      imm_j: begin
        // reassemble offset, bit 0 always zero
        imm = {{11{sign}},
               iw.j.imm_20,
               iw.j.imm_19_12,
               iw.j.imm_11,
               iw.j.imm_10_1,
               1'b0};
      end
      default: begin
        // unused encoding
        imm = '0;
      end
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
`include "rv_consts.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic                  reg_we,
  input  logic [`RV_XLEN-1:0]   wb_data,
  output logic [`RV_XLEN-1:0]   rs1_data
);

  // 32 x 32 storage
  // entry 0 can be written but is never read
  logic [`RV_XLEN-1:0] regs [0:(1 << `RV_REG_AW)-1];

  // single write port
  // reg_we already carries the accept and the rd != 0 check
  always_ff @(posedge clk) begin
    if (reg_we) begin
      regs[rd] <= wb_data;
    end
  end

  // combinational read, x0 hard-wired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];

endmodule

// ==== rv_exec.sv ====
`include "rv_consts.svh"

module rv_exec import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  fire,
  input  logic                  reg_we,
  input  logic [`RV_XLEN-1:0]   rs1_data,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic [`RV_REG_AW-1:0] rd,
  input  op_a_sel_e             op_a_sel,
  input  pc_sel_e               pc_sel,
  input  wb_sel_e               wb_sel,
  output logic [`RV_XLEN-1:0]   pc,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic [`RV_XLEN-1:0]   retire_pc,
  output logic [`RV_XLEN-1:0]   retire_data,
  output logic                  retire_valid,
  output logic                  retire_we,
  output logic [`RV_REG_AW-1:0] retire_rd
);

  // sequential pc, also the link value
  logic [`RV_XLEN-1:0] pc_inc;
  // first adder operand
  logic [`RV_XLEN-1:0] op_a;
  // shared adder output
  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] next_pc;

  assign pc_inc = pc + `RV_XLEN'd4;

  // operand a by opcode class
  always_comb begin
    case (op_a_sel)
      op_a_rs1: op_a = rs1_data;
      op_a_pc:  op_a = pc;
      default:  op_a = '0;
    endcase
  end

  // one adder serves addi, lui, auipc and both jump targets
  assign sum = op_a + imm;

  // jump targets drop bit 0 (jalr rule, harmless for jal)
  assign next_pc = (pc_sel == pc_jump) ? {sum[`RV_XLEN-1:1], 1'b0} : pc_inc;

  // link for jumps, adder result otherwise
  assign wb_data = (wb_sel == wb_link) ? pc_inc : sum;

  // pc only moves on an accepted instruction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else if (fire) begin
      pc <= next_pc;
    end
  end

  // retire strobes, one cycle after each accept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
      retire_we    <= 1'b0;
    end else begin
      retire_valid <= fire;
      // reg_we is low on idle cycles
      retire_we    <= reg_we;
    end
  end

  // retire payload, held between accepts
  always_ff @(posedge clk) begin
    if (fire) begin
      retire_pc   <= pc;
      retire_rd   <= rd;
      retire_data <= wb_data;
    end
  end

endmodule

// ==== rv_core.sv ====
`include "rv_consts.svh"

module rv_core import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`RV_XLEN-1:0]   inst,
  input  logic                  inst_valid,
  output logic                  inst_ready,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  retire_valid,
  output logic [`RV_XLEN-1:0]   retire_pc,
  output logic                  retire_we,
  output logic [`RV_REG_AW-1:0] retire_rd,
  output logic [`RV_XLEN-1:0]   retire_data,
  output logic                  halted
);

  // decode to datapath
  logic                  fire;
  logic                  reg_we;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rd;
  imm_sel_e              imm_sel;
  op_a_sel_e             op_a_sel;
  pc_sel_e               pc_sel;
  wb_sel_e               wb_sel;

  // datapath values
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   wb_data;

  // handshake, run/halt, selects
  rv_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .halted     (halted),
    .fire       (fire),
    .reg_we     (reg_we),
    .rs1        (rs1),
    .rd         (rd),
    .imm_sel    (imm_sel),
    .op_a_sel   (op_a_sel),
    .pc_sel     (pc_sel),
    .wb_sel     (wb_sel)
  );

  rv_imm_gen u_imm_gen (
    .inst    (inst),
    .imm_sel (imm_sel),
    .imm     (imm)
  );

  // write comes back from exec on the accept edge
  rv_regfile u_regfile (
    .clk      (clk),
    .rs1      (rs1),
    .rd       (rd),
    .reg_we   (reg_we),
    .wb_data  (wb_data),
    .rs1_data (rs1_data)
  );

  rv_exec u_exec (
    .clk          (clk),
    .arst_n       (arst_n),
    .fire         (fire),
    .reg_we       (reg_we),
    .rs1_data     (rs1_data),
    .imm          (imm),
    .rd           (rd),
    .op_a_sel     (op_a_sel),
    .pc_sel       (pc_sel),
    .wb_sel       (wb_sel),
    .pc           (pc),
    .wb_data      (wb_data),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd)
  );

endmodule

// ==== rv_core_props.sv ====
`include "rv_consts.svh"

module rv_core_props (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  inst_valid,
  input logic                  inst_ready,
  input logic                  halted,
  input logic                  retire_valid,
  input logic                  retire_we,
  input logic [`RV_REG_AW-1:0] retire_rd
);

  // failed assertions so far
  int fail_count = 0;

  // halt withholds ready
  ready_off_in_halt: assert property (
    @(posedge clk) disable iff (!arst_n) halted |-> !inst_ready
  ) else begin
    fail_count++;
    $error("inst_ready high while halted");
  end

  // one retire pulse, exactly one cycle after each accept
  retire_after_accept: assert property (
    @(posedge clk) disable iff (!arst_n) retire_valid == $past(inst_valid && inst_ready)
  ) else begin
    fail_count++;
    $error("retire_valid does not follow the accept by one cycle");
  end

  // x0 is never a write target
  no_write_to_x0: assert property (
    @(posedge clk) disable iff (!arst_n) retire_we |-> (retire_rd != '0)
  ) else begin
    fail_count++;
    $error("retire_we high with retire_rd zero");
  end

endmodule

// ==== tb_checker.sv ====
`include "rv_consts.svh"

module tb_checker (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`RV_XLEN-1:0]   inst,
  input  logic                  inst_valid,
  input  logic                  inst_ready,
  input  logic [`RV_XLEN-1:0]   pc,
  input  logic                  retire_valid,
  input  logic [`RV_XLEN-1:0]   retire_pc,
  input  logic                  retire_we,
  input  logic [`RV_REG_AW-1:0] retire_rd,
  input  logic [`RV_XLEN-1:0]   retire_data,
  input  logic                  halted,
  input  logic [2:0]            phase,
  output int                    error_count,
  output int                    retire_count
);

  // reference state
  logic [`RV_XLEN-1:0]   mregs [0:31];
  logic [`RV_XLEN-1:0]   mpc;
  logic                  mhalted;

  // prediction for the instruction accepted last cycle
  logic                  pend;
  logic [2:0]            pend_phase;
  logic [`RV_XLEN-1:0]   exp_pc;
  logic [`RV_XLEN-1:0]   exp_data;
  logic                  exp_we;
  logic [`RV_REG_AW-1:0] exp_rd;

  logic [2:0]            last_phase;
  // index 5 is the idle tail after the last test
  int                    phase_errors [0:5];
  int                    phase_retires [0:5];

  function automatic string phase_name(input logic [2:0] p);
    case (p)
      3'd0: return "addi";
      3'd1: return "upper";
      3'd2: return "jump";
      3'd3: return "mixed_gaps";
      3'd4: return "ebreak";
      default: return "tail";
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act,
                         input logic [2:0] p);
    if (act !== exp) begin
      $display("FAILED %s: %s expected %h actual %h", phase_name(p), what, exp, act);
      phase_errors[p]++;
      error_count++;
    end
  endtask

  // decode straight from the RV32I encoding, then step the model
  task automatic predict(input logic [31:0] word);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] src;
    logic [31:0] npc;
    opc   = word[6:0];
    rd    = word[11:7];
    f3    = word[14:12];
    rs1   = word[19:15];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_u = {word[31:12], 12'h000};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    src   = (rs1 == 5'd0) ? 32'd0 : mregs[rs1];
    npc   = mpc + 32'd4;
    exp_we   = 1'b0;
    exp_data = '0;
    case (opc)
      `RV_OP_IMM: begin
        if (f3 == 3'b000) begin
          exp_we   = 1'b1;
          exp_data = src + imm_i;
        end
      end
      `RV_OP_LUI: begin
        exp_we   = 1'b1;
        exp_data = imm_u;
      end
      `RV_OP_AUIPC: begin
        exp_we   = 1'b1;
        exp_data = mpc + imm_u;
      end
      `RV_OP_JAL: begin
        exp_we   = 1'b1;
        exp_data = mpc + 32'd4;
        npc      = mpc + imm_j;
      end
      `RV_OP_JALR: begin
        if (f3 == 3'b000) begin
          exp_we   = 1'b1;
          exp_data = mpc + 32'd4;
          npc      = (src + imm_i) & ~32'd1;
        end
      end
      `RV_OP_SYSTEM: begin
        if (word == 32'h0010_0073) begin
          mhalted = 1'b1;
        end
      end
      default: begin
        // unsupported, plain pc+4
        exp_we = 1'b0;
      end
    endcase
    if (rd == 5'd0) begin
      exp_we = 1'b0;
    end
    exp_pc = mpc;
    exp_rd = rd;
    if (exp_we) begin
      mregs[rd] = exp_data;
    end
    mpc = npc;
  endtask

  initial begin
    error_count  = 0;
    retire_count = 0;
    pend         = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    for (int i = 0; i < 6; i++) begin
      phase_errors[i]  = 0;
      phase_retires[i] = 0;
    end
  end

  // outputs read before this edge's updates land
  always @(posedge clk) begin
    if (!arst_n) begin
      mpc        = `RV_RESET_PC;
      mhalted    = 1'b0;
      pend       = 1'b0;
      last_phase = phase;
    end else begin
      if (pend) begin
        compare("retire_valid", 32'd1, retire_valid, pend_phase);
        compare("retire_pc", exp_pc, retire_pc, pend_phase);
        compare("retire_we", exp_we, retire_we, pend_phase);
        // payload only defined for writers
        if (exp_we) begin
          compare("retire_rd", exp_rd, retire_rd, pend_phase);
          compare("retire_data", exp_data, retire_data, pend_phase);
        end
        phase_retires[pend_phase]++;
        retire_count++;
      end else begin
        compare("retire_valid", 32'd0, retire_valid, phase);
      end
      // pc holds across idle cycles
      compare("pc", mpc, pc, phase);
      compare("halted", mhalted, halted, phase);
      compare("inst_ready", !mhalted, inst_ready, phase);
      if (phase != last_phase) begin
        $display("test %s: %0d retires, %0d errors, %s", phase_name(last_phase),
                 phase_retires[last_phase], phase_errors[last_phase],
                 (phase_errors[last_phase] == 0) ? "ok" : "bad");
        last_phase = phase;
      end
      pend = 1'b0;
      if (inst_valid && inst_ready) begin
        predict(inst);
        pend       = 1'b1;
        pend_phase = phase;
      end
    end
  end

endmodule

// ==== tb_top.sv ====
`include "rv_consts.svh"

module tb_top;

  // instructions per test
  // the addi count includes its seeding prefix
  localparam int N_ADDI      = 40;
  localparam int N_UPPER     = 30;
  localparam int N_JUMP      = 30;
  localparam int N_MIXED     = 60;
  // offers after ebreak that are never accepted
  localparam int N_REFUSED   = 8;
  localparam int N_ACCEPTED  = N_ADDI + N_UPPER + N_JUMP + N_MIXED + 1;
  localparam int N_TOTAL     = N_ACCEPTED + N_REFUSED;
  // gap of up to 3 plus the accept cycle
  localparam int CYCLE_LIMIT = N_TOTAL * 4 + 100;

  logic                  clk;
  logic                  arst_n;
  logic [`RV_XLEN-1:0]   inst;
  logic                  inst_valid;
  logic                  inst_ready;
  logic [`RV_XLEN-1:0]   pc;
  logic                  retire_valid;
  logic [`RV_XLEN-1:0]   retire_pc;
  logic                  retire_we;
  logic [`RV_REG_AW-1:0] retire_rd;
  logic [`RV_XLEN-1:0]   retire_data;
  logic                  halted;

  logic [2:0]            phase;
  integer                seed;
  int                    cycles = 0;
  int                    error_count;
  int                    retire_count;

  rv_core rv_core_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  tb_checker tb_checker_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .phase        (phase),
    .error_count  (error_count),
    .retire_count (retire_count)
  );

  bind rv_core rv_core_props rv_core_props_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .halted       (halted),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // x0..x7 only so reads mostly hit written registers
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = $random(seed);
    return {2'b00, r[2:0]};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // j-type scrambles the offset bits
  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic logic [31:0] gen_addi();
    logic [31:0] r;
    r = $random(seed);
    return enc_i(`RV_OP_IMM, pick_reg(), pick_reg(), r[11:0]);
  endfunction

  function automatic logic [31:0] gen_upper();
    logic [31:0] r;
    r = $random(seed);
    return enc_u(r[31] ? `RV_OP_AUIPC : `RV_OP_LUI, pick_reg(), r[19:0]);
  endfunction

  function automatic logic [31:0] gen_jump();
    logic [31:0] r;
    r = $random(seed);
    if (r[31]) begin
      return enc_j(pick_reg(), r[20:0]);
    end else begin
      return enc_i(`RV_OP_JALR, pick_reg(), pick_reg(), r[11:0]);
    end
  endfunction

  // all kinds plus R-type and load words that must retire as no-ops
  function automatic logic [31:0] gen_mixed();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0, 3'd1, 3'd2: return gen_addi();
      3'd3, 3'd4: return gen_upper();
      3'd5, 3'd6: return gen_jump();
      default: return enc_i(r[3] ? 7'b011_0011 : 7'b000_0011, pick_reg(), pick_reg(), r[15:4]);
    endcase
  endfunction

  // random idle gap, then hold the word until accepted
  task automatic issue(input logic [31:0] word);
    logic [31:0] r;
    r = $random(seed);
    repeat (r[1:0]) begin
      @(negedge clk);
      inst_valid = 1'b0;
    end
    @(negedge clk);
    inst       = word;
    inst_valid = 1'b1;
    @(posedge clk);
    while (!inst_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic start_phase(input logic [2:0] p);
    @(negedge clk);
    inst_valid = 1'b0;
    phase      = p;
  endtask

  initial begin
    logic [31:0] r;
    int          asserts;
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst       = '0;
    inst_valid = 1'b0;
    phase      = 3'd0;
    seed       = 32'h6817;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // x1..x7 get defined values from x0 first
    for (int k = 1; k < 8; k++) begin
      r = $random(seed);
      issue(enc_i(`RV_OP_IMM, k[4:0], 5'd0, r[11:0]));
    end
    for (int k = 7; k < N_ADDI; k++) begin
      issue(gen_addi());
    end

    start_phase(3'd1);
    for (int k = 0; k < N_UPPER; k++) begin
      issue(gen_upper());
    end

    start_phase(3'd2);
    for (int k = 0; k < N_JUMP; k++) begin
      issue(gen_jump());
    end

    start_phase(3'd3);
    for (int k = 0; k < N_MIXED; k++) begin
      issue(gen_mixed());
    end

    // halt, then keep offering one pending word the core must refuse
    start_phase(3'd4);
    issue(32'h0010_0073);
    @(negedge clk);
    inst       = gen_mixed();
    inst_valid = 1'b1;
    repeat (N_REFUSED - 1) @(negedge clk);
    start_phase(3'd5);
    repeat (2) @(posedge clk);
    // counters settle after the last checked edge
    @(negedge clk);

    asserts = rv_core_i.rv_core_props_i.fail_count;
    $display("summary: 5 tests, %0d retires checked, %0d errors, %0d assertion failures",
             retire_count, error_count, asserts);
    if (retire_count != N_ACCEPTED) begin
      $display("retire count is %0d but %0d instructions were accepted",
               retire_count, N_ACCEPTED);
    end
    if (error_count == 0 && asserts == 0 && retire_count == N_ACCEPTED) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
rv_pkg.sv
rv_ctrl.sv
rv_imm_gen.sv
rv_regfile.sv
rv_exec.sv
rv_core.sv
rv_core_props.sv
tb_checker.sv
tb_top.sv
